// ==== filelist.f ====
hdl/dcache_pkg.sv
hdl/dcache_bus_pkg.sv
hdl/wb_dcache_controller.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

// ==== sim/dcache_tb.sv ====
module dcache_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int ACK_LIMIT      = 30;
    localparam int CYCLES_PER_TEST = 40;

    typedef struct {
        string       name;
        bit          wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        bit          sel;
        int          exp_rd;
        int          exp_wr;
        logic [27:0] wb_line;
        int          exp_cycles;
    } test_t;

    logic clk;
    logic rst_n;
    logic dmem_sel;

    dcache_bus_pkg::lsu_dcache_req_t lsu_req;
    dcache_bus_pkg::dcache_lsu_rsp_t lsu_rsp;
    dcache_bus_pkg::dcache_mem_req_t mem_req;
    dcache_bus_pkg::mem_dcache_rsp_t mem_rsp;

    test_t      tests[$];
    bit         tests_loaded;
    logic [7:0] ref_mem [logic [31:0]];
    int         err_count;
    int         n_pass;
    int         n_fail;

    // Memory traffic seen during the current test
    int           mem_rd_cnt;
    int           mem_wr_cnt;
    logic [27:0]  rd_line_seen;
    logic [27:0]  wb_line_seen;
    logic [127:0] wb_data_seen;
    logic         req_prev;

    dcache_top dut0 (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .lsu_req_i  (lsu_req),
        .lsu_rsp_o  (lsu_rsp),
        .dmem_sel_i (dmem_sel),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    dcache_mem_model u_mem (
        .clk_i     (clk),
        .rst_ni    (rst_n),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // A transfer starts when the request rises
    always @(negedge clk) begin
        if (mem_req.req && !req_prev) begin
            if (mem_req.wr) begin
                mem_wr_cnt++;
                wb_line_seen = mem_req.line_addr;
                wb_data_seen = mem_req.wdata;
            end else begin
                mem_rd_cnt++;
                rd_line_seen = mem_req.line_addr;
            end
        end
        req_prev = mem_req.req;
    end

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    // Byte-level reference of main memory as the LSU sees it
    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        w = fill_word({a[31:2], 2'b00});
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        logic [31:0] w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = ref_byte({a[31:2], 2'b00} + 32'(b));
        end
        return w;
    endfunction

    function automatic logic [127:0] ref_line(input logic [27:0] la);
        logic [127:0] l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = ref_word({la, 4'h0} + 32'(w * 4));
        end
        return l;
    endfunction

    function automatic void ref_write(input logic [31:0] a, input logic [31:0] d,
                                      input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_mem[{a[31:2], 2'b00} + 32'(b)] = d[b*8 +: 8];
            end
        end
    endfunction

    function automatic void add_test(string name, bit wr, logic [31:0] addr,
                                     logic [31:0] wdata, logic [3:0] be, bit sel, int exp_rd,
                                     int exp_wr, logic [27:0] wb_line, int exp_cycles);
        tests.push_back(test_t'{name, wr, addr, wdata, be, sel, exp_rd, exp_wr, wb_line,
                                exp_cycles});
    endfunction

    function automatic void report_mismatch(string name, string what, logic [127:0] exp,
                                            logic [127:0] act);
        $display("Error: %s %s expected %0h actual %0h", name, what, exp, act);
        err_count++;
    endfunction

    function automatic void report_test(string name, int errs_before);
        if (err_count == errs_before) begin
            n_pass++;
            $display("%-20s ok", name);
        end else begin
            n_fail++;
            $display("%-20s failed", name);
        end
    endfunction

    function automatic void load_tests();
        // name, wr, addr, wdata, be, sel, mem reads, mem writes, victim line, ack cycles
        add_test("rd_miss_clean",     0, 32'h0000_1024, 32'h0,         4'hf, 1, 1, 0, 28'h0,   0);
        add_test("rd_hit_same_line",  0, 32'h0000_1028, 32'h0,         4'hf, 1, 0, 0, 28'h0,   2);
        add_test("wr_hit_partial",    1, 32'h0000_1024, 32'hdead_beef, 4'h5, 1, 0, 0, 28'h0,   2);
        add_test("rd_merged_word",    0, 32'h0000_1024, 32'h0,         4'hf, 1, 0, 0, 28'h0,   2);
        add_test("rd_evict_dirty",    0, 32'h0000_5020, 32'h0,         4'hf, 1, 1, 1, 28'h102, 0);
        add_test("rd_refill_orig",    0, 32'h0000_1024, 32'h0,         4'hf, 1, 1, 0, 28'h0,   0);
        add_test("rd_deselected",     0, 32'h0000_3030, 32'h0,         4'hf, 0, 0, 0, 28'h0,   0);
        add_test("wr_miss_alloc",     1, 32'h0000_2038, 32'h1234_5678, 4'hf, 1, 1, 0, 28'h0,   0);
        add_test("rd_after_wr_miss",  0, 32'h0000_2038, 32'h0,         4'hf, 1, 0, 0, 28'h0,   2);
        add_test("wr_miss_dirty",     1, 32'h0000_7034, 32'ha5a5_5a5a, 4'h8, 1, 1, 1, 28'h203, 0);
        add_test("wr_deselected",     1, 32'h0000_7034, 32'hffff_ffff, 4'hf, 0, 0, 0, 28'h0,   0);
        add_test("rd_after_deselect", 0, 32'h0000_7034, 32'h0,         4'hf, 1, 0, 0, 28'h0,   2);
        add_test("rd_evict_back",     0, 32'h0000_2038, 32'h0,         4'hf, 1, 1, 1, 28'h703, 0);
        add_test("rd_other_word_hit", 0, 32'h0000_2030, 32'h0,         4'hf, 1, 0, 0, 28'h0,   2);
        tests_loaded = 1'b1;
    endfunction

    task automatic check_reset_quiet();
        int errs_before;
        bit saw;
        errs_before = err_count;
        saw         = 1'b0;
        repeat (4) begin
            @(negedge clk);
            saw |= lsu_rsp.ack | mem_req.req;
        end
        assert (!saw) else begin
            $display("reset_quiet: acknowledge or memory request raised with nothing pending");
            err_count++;
        end
        report_test("reset_quiet", errs_before);
    endtask

    task automatic check_response(input test_t t, input int cycles);
        logic [31:0] exp_word;
        if (t.exp_cycles != 0) begin
            assert (cycles == t.exp_cycles) else report_mismatch(t.name, "ack cycles",
                                                                 t.exp_cycles, cycles);
        end
        if (!t.wr) begin
            exp_word = ref_word(t.addr);
            assert (lsu_rsp.rdata === exp_word) else report_mismatch(t.name, "read data",
                                                                     exp_word, lsu_rsp.rdata);
        end
        assert (mem_rd_cnt == t.exp_rd) else report_mismatch(t.name, "memory reads",
                                                             t.exp_rd, mem_rd_cnt);
        assert (mem_wr_cnt == t.exp_wr) else report_mismatch(t.name, "memory writes",
                                                             t.exp_wr, mem_wr_cnt);
        if (t.exp_rd > 0) begin
            assert (rd_line_seen == t.addr[31:4]) else report_mismatch(t.name, "fill line",
                                                                       t.addr[31:4], rd_line_seen);
        end
        if (t.exp_wr > 0) begin
            assert (wb_line_seen == t.wb_line) else report_mismatch(t.name, "victim line",
                                                                    t.wb_line, wb_line_seen);
            assert (wb_data_seen === ref_line(t.wb_line))
                else report_mismatch(t.name, "victim data", ref_line(t.wb_line), wb_data_seen);
        end
        if (t.wr) begin
            ref_write(t.addr, t.wdata, t.be);
        end
    endtask

    task automatic run_test(input test_t t);
        int errs_before;
        int cycles;
        bit acked;
        bit saw_ack;
        bit saw_req;
        errs_before = err_count;
        mem_rd_cnt  = 0;
        mem_wr_cnt  = 0;
        cycles      = 0;
        acked       = 1'b0;
        saw_ack     = 1'b0;
        saw_req     = 1'b0;
        @(posedge clk);
        lsu_req.req   <= 1'b1;
        lsu_req.wr    <= t.wr;
        lsu_req.addr  <= t.addr;
        lsu_req.wdata <= t.wdata;
        lsu_req.be    <= t.be;
        dmem_sel      <= t.sel;
        if (!t.sel) begin
            // Deselected access has a fixed window
            repeat (10) begin
                @(negedge clk);
                saw_ack |= lsu_rsp.ack;
                saw_req |= mem_req.req;
            end
            assert (!saw_ack) else begin
                $display("%s: acknowledge given while memory was deselected", t.name);
                err_count++;
            end
            assert (!saw_req) else begin
                $display("%s: memory request issued while memory was deselected", t.name);
                err_count++;
            end
        end else begin
            while (!acked && cycles < ACK_LIMIT) begin
                @(negedge clk);
                cycles++;
                acked = lsu_rsp.ack;
            end
            assert (acked) else begin
                $display("%s: no acknowledge within %0d cycles", t.name, ACK_LIMIT);
                err_count++;
            end
            if (acked) begin
                check_response(t, cycles);
            end
        end
        @(posedge clk);
        lsu_req.req <= 1'b0;
        dmem_sel    <= 1'b1;
        report_test(t.name, errs_before);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        dmem_sel  = 1'b1;
        lsu_req   = '0;
        req_prev  = 1'b0;
        err_count = 0;
        n_pass    = 0;
        n_fail    = 0;
        load_tests();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_quiet();
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("Tests %0d, passed %0d, failed %0d, failed checks %0d",
                 n_pass + n_fail, n_pass, n_fail, err_count);
        if (n_fail == 0 && err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (tests_loaded);
        #((tests.size() * CYCLES_PER_TEST + 10) * CLK_PERIOD);
        $display("Watchdog expired, the test sequence did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sim/dcache_mem_model.sv ====
module dcache_mem_model (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  dcache_bus_pkg::dcache_mem_req_t mem_req_i,
    output dcache_bus_pkg::mem_dcache_rsp_t mem_rsp_o
);

    // Lines that were written back, all others come from the fill pattern
    logic [dcache_pkg::DCACHE_LINE_W-1:0] lines [logic [27:0]];

    logic [31:0] lfsr_q;
    logic        busy_q;
    logic [2:0]  wait_q;

    dcache_bus_pkg::dcache_mem_req_t held_q;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic logic [dcache_pkg::DCACHE_LINE_W-1:0] read_line(input logic [27:0] la);
        logic [dcache_pkg::DCACHE_LINE_W-1:0] l;
        if (lines.exists(la)) begin
            return lines[la];
        end
        for (int w = 0; w < dcache_pkg::DCACHE_WORDS_PER_LINE; w++) begin
            l[w*32 +: 32] = fill_word({la, 4'h0} + 32'(w * 4));
        end
        return l;
    endfunction

    always @(posedge clk_i) begin
        logic [31:0] s1;
        logic [31:0] s2;
        if (!rst_ni) begin
            busy_q          <= 1'b0;
            wait_q          <= '0;
            lfsr_q          <= 32'h13c4;
            mem_rsp_o.ack   <= 1'b0;
            mem_rsp_o.rdata <= '0;
        end else begin
            mem_rsp_o.ack <= 1'b0;
            if (busy_q) begin
                if (wait_q == 3'd1) begin
                    // Single-cycle acknowledge, read data valid with it
                    busy_q        <= 1'b0;
                    mem_rsp_o.ack <= 1'b1;
                    if (held_q.wr) begin
                        lines[held_q.line_addr] = held_q.wdata;
                    end else begin
                        mem_rsp_o.rdata <= read_line(held_q.line_addr);
                    end
                end else begin
                    wait_q <= wait_q - 3'd1;
                end
            end else if (mem_req_i.req && !mem_rsp_o.ack) begin
                // Two LFSR bits give a delay of 1 to 4 cycles
                s1     = lfsr_next(lfsr_q);
                s2     = lfsr_next(s1);
                lfsr_q <= s2;
                wait_q <= {1'b0, s2[0], s1[0]} + 3'd1;
                held_q <= mem_req_i;
                busy_q <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/dcache_top.sv ====
module dcache_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    // LSU port
    input  dcache_bus_pkg::lsu_dcache_req_t lsu_req_i,
    output dcache_bus_pkg::dcache_lsu_rsp_t lsu_rsp_o,
    input  logic                            dmem_sel_i,

    // Main memory port
    output dcache_bus_pkg::dcache_mem_req_t mem_req_o,
    input  dcache_bus_pkg::mem_dcache_rsp_t mem_rsp_i
);

    dcache_pkg::dcache_addr_u addr;

    logic cache_hit;
    logic cache_dirty;
    logic cache_wr;
    logic cache_line_wr;
    logic cache_writeback_req;
    logic lsu_ack;
    logic mem_req;
    logic mem_wr;

    logic [dcache_pkg::DCACHE_TAG_W-1:0]  victim_tag;
    logic [dcache_pkg::DCACHE_LINE_W-1:0] cached_line;
    logic [31:0]                          cached_word;

    assign addr.raw = lsu_req_i.addr;

    wb_dcache_controller u_ctrl (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .cache_hit_i           (cache_hit),
        .cache_dirty_bit_i     (cache_dirty),
        .lsu_req_i             (lsu_req_i.req),
        .lsu_wr_i              (lsu_req_i.wr),
        .dmem_sel_i            (dmem_sel_i),
        .mem_ack_i             (mem_rsp_i.ack),
        .cache_wr_o            (cache_wr),
        .cache_line_wr_o       (cache_line_wr),
        .cache_writeback_req_o (cache_writeback_req),
        .lsu_ack_o             (lsu_ack),
        .mem_req_o             (mem_req),
        .mem_wr_o              (mem_wr)
    );

    dcache_tag_store u_tags (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .addr_i       (addr),
        .line_wr_i    (cache_line_wr),
        .word_wr_i    (cache_wr),
        .hit_o        (cache_hit),
        .dirty_o      (cache_dirty),
        .victim_tag_o (victim_tag)
    );

    dcache_data_store u_data (
        .clk_i     (clk_i),
        .addr_i    (addr),
        .word_wr_i (cache_wr),
        .wdata_i   (lsu_req_i.wdata),
        .be_i      (lsu_req_i.be),
        .line_wr_i (cache_line_wr),
        .line_i    (mem_rsp_i.rdata),
        .word_o    (cached_word),
        .line_o    (cached_line)
    );

    always_comb begin
        lsu_rsp_o.ack   = lsu_ack;
        lsu_rsp_o.rdata = cached_word;

        mem_req_o.req   = mem_req;
        mem_req_o.wr    = mem_wr;
        // Write-back targets the old line, fills target the requested one
        if (cache_writeback_req) begin
            mem_req_o.line_addr = {victim_tag, addr.parts.idx};
        end else begin
            mem_req_o.line_addr = {addr.parts.tag, addr.parts.idx};
        end
        mem_req_o.wdata = cached_line;
    end

endmodule

// ==== hdl/dcache_data_store.sv ====
module dcache_data_store (
    input  logic                                 clk_i,
    input  dcache_pkg::dcache_addr_u             addr_i,

    // Store from the LSU
    input  logic                                 word_wr_i,
    input  logic [31:0]                          wdata_i,
    input  logic [3:0]                           be_i,

    // Fill from memory
    input  logic                                 line_wr_i,
    input  logic [dcache_pkg::DCACHE_LINE_W-1:0] line_i,

    output logic [31:0]                          word_o,
    output logic [dcache_pkg::DCACHE_LINE_W-1:0] line_o
);

    // Each line kept as an array of 32-bit words
    logic [dcache_pkg::DCACHE_WORDS_PER_LINE-1:0][31:0] lines_q [dcache_pkg::DCACHE_SETS];

    logic [dcache_pkg::DCACHE_IDX_W-1:0]  idx;
    logic [dcache_pkg::DCACHE_WOFF_W-1:0] woff;

    assign idx  = addr_i.parts.idx;
    assign woff = addr_i.parts.word_off;

    always_ff @(posedge clk_i) begin
        if (line_wr_i) begin
            lines_q[idx] <= line_i;
        end else if (word_wr_i) begin
            // Merge only the enabled bytes
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    lines_q[idx][woff][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Both reads are combinational
    assign word_o = lines_q[idx][woff];
    assign line_o = lines_q[idx];

    // A store and a fill are never issued in the same cycle
    a_wr_exclusive: assert property (
        @(posedge clk_i)
        !(word_wr_i && line_wr_i)
    );

endmodule

// ==== hdl/dcache_tag_store.sv ====
module dcache_tag_store (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  dcache_pkg::dcache_addr_u            addr_i,
    input  logic                                line_wr_i,
    input  logic                                word_wr_i,
    output logic                                hit_o,
    output logic                                dirty_o,
    output logic [dcache_pkg::DCACHE_TAG_W-1:0] victim_tag_o
);

    logic [dcache_pkg::DCACHE_SETS-1:0]  valid_q;
    logic [dcache_pkg::DCACHE_SETS-1:0]  dirty_q;
    logic [dcache_pkg::DCACHE_TAG_W-1:0] tag_q [dcache_pkg::DCACHE_SETS];

    logic [dcache_pkg::DCACHE_IDX_W-1:0] idx;
    logic [dcache_pkg::DCACHE_TAG_W-1:0] req_tag;

    assign idx     = addr_i.parts.idx;
    assign req_tag = addr_i.parts.tag;

    // Valid and dirty flags per set
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (line_wr_i) begin
            // Fresh line from memory is clean
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
        end else if (word_wr_i) begin
            dirty_q[idx] <= 1'b1;
        end
    end

    // Tag loaded with the fill
    always_ff @(posedge clk_i) begin
        if (line_wr_i) begin
            tag_q[idx] <= req_tag;
        end
    end

    assign hit_o        = valid_q[idx] && (tag_q[idx] == req_tag);
    assign dirty_o      = valid_q[idx] && dirty_q[idx];
    // Old tag, only meaningful when the set is dirty
    assign victim_tag_o = tag_q[idx];

    // Word writes only land on a resident line
    a_word_wr_on_hit: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        word_wr_i |-> hit_o
    );

endmodule

// ==== hdl/wb_dcache_controller.sv ====
module wb_dcache_controller (
    input  logic clk_i,
    input  logic rst_ni,

    // From the tag store
    input  logic cache_hit_i,
    input  logic cache_dirty_bit_i,

    // LSU side
    input  logic lsu_req_i,
    input  logic lsu_wr_i,
    input  logic dmem_sel_i,

    // Memory side
    input  logic mem_ack_i,

    // Strobes to the stores
    output logic cache_wr_o,
    output logic cache_line_wr_o,
    output logic cache_writeback_req_o,

    output logic lsu_ack_o,
    output logic mem_req_o,
    output logic mem_wr_o
);

    dcache_pkg::type_dcache_states_e state_q;
    dcache_pkg::type_dcache_states_e state_d;

    logic access_hit;
    logic access_miss;

    assign access_hit  = lsu_req_i & dmem_sel_i & cache_hit_i;
    assign access_miss = lsu_req_i & dmem_sel_i & ~cache_hit_i;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= dcache_pkg::DCACHE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d               = state_q;
        lsu_ack_o             = 1'b0;
        mem_req_o             = 1'b0;
        mem_wr_o              = 1'b0;
        cache_writeback_req_o = 1'b0;
        cache_line_wr_o       = 1'b0;
        cache_wr_o            = 1'b0;

        unique case (state_q)
            dcache_pkg::DCACHE_IDLE: begin
                if (access_hit) begin
                    // Store hits write the word right away
                    if (lsu_wr_i) begin
                        state_d    = dcache_pkg::DCACHE_WRITE;
                        cache_wr_o = 1'b1;
                    end else begin
                        state_d = dcache_pkg::DCACHE_READ;
                    end
                end else if (access_miss) begin
                    if (cache_dirty_bit_i) begin
                        // Victim goes out before the fill
                        state_d               = dcache_pkg::DCACHE_WRITE_BACK;
                        mem_req_o             = 1'b1;
                        mem_wr_o              = 1'b1;
                        cache_writeback_req_o = 1'b1;
                    end else begin
                        state_d = dcache_pkg::DCACHE_ALLOCATE;
                    end
                end else begin
                    state_d = dcache_pkg::DCACHE_IDLE;
                end
            end
            dcache_pkg::DCACHE_READ: begin
                // Read data comes straight from the data store
                state_d   = dcache_pkg::DCACHE_IDLE;
                lsu_ack_o = 1'b1;
            end
            dcache_pkg::DCACHE_WRITE: begin
                state_d   = dcache_pkg::DCACHE_IDLE;
                lsu_ack_o = 1'b1;
            end
            dcache_pkg::DCACHE_ALLOCATE: begin
                if (mem_ack_i) begin
                    // Line lands on this edge and the held request then hits
                    state_d         = dcache_pkg::DCACHE_IDLE;
                    cache_line_wr_o = 1'b1;
                end else begin
                    state_d   = dcache_pkg::DCACHE_ALLOCATE;
                    mem_req_o = 1'b1;
                end
            end
            dcache_pkg::DCACHE_WRITE_BACK: begin
                if (mem_ack_i) begin
                    state_d = dcache_pkg::DCACHE_ALLOCATE;
                end else begin
                    state_d               = dcache_pkg::DCACHE_WRITE_BACK;
                    mem_req_o             = 1'b1;
                    mem_wr_o              = 1'b1;
                    cache_writeback_req_o = 1'b1;
                end
            end
            default: begin
                state_d = dcache_pkg::DCACHE_IDLE;
            end
        endcase

        // Access outside cacheable memory kills whatever is in progress
        if (!dmem_sel_i) begin
            state_d    = dcache_pkg::DCACHE_IDLE;
            cache_wr_o = 1'b0;
            mem_req_o  = 1'b0;
        end
    end

    // Memory traffic only serves a selected access that the LSU still holds
    a_no_req_unselected: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mem_req_o |-> lsu_req_i && dmem_sel_i
    );

    // Fill strobe answers the read request held in the cycle before
    a_line_wr_in_allocate: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cache_line_wr_o |-> (state_q == dcache_pkg::DCACHE_ALLOCATE)
                            && $past(mem_req_o) && !$past(mem_wr_o)
    );

endmodule

// ==== hdl/dcache_bus_pkg.sv ====
package dcache_bus_pkg;

    // LSU to cache request, held until acknowledged
    typedef struct packed {
        logic        req;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } lsu_dcache_req_t;

    // Cache to LSU response
    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } dcache_lsu_rsp_t;

    // Cache to memory request, one full line per transfer
    typedef struct packed {
        logic         req;
        logic         wr;
        // Byte address bits 31:4
        logic [27:0]  line_addr;
        logic [127:0] wdata;
    } dcache_mem_req_t;

    // Memory to cache response, ack is a single-cycle pulse
    typedef struct packed {
        logic         ack;
        logic [127:0] rdata;
    } mem_dcache_rsp_t;

endpackage

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    // Cache geometry
    localparam int unsigned DCACHE_WORDS_PER_LINE = 4;
    localparam int unsigned DCACHE_SETS           = 16;
    localparam int unsigned DCACHE_TAG_W          = 24;
    localparam int unsigned DCACHE_IDX_W          = 4;
    localparam int unsigned DCACHE_LINE_W         = 128;

    // Word select within a line
    localparam int unsigned DCACHE_WOFF_W = $clog2(DCACHE_WORDS_PER_LINE);

    // Controller states
    typedef enum logic [2:0] {
        DCACHE_IDLE,
        DCACHE_READ,
        DCACHE_WRITE,
        DCACHE_ALLOCATE,
        DCACHE_WRITE_BACK
    } type_dcache_states_e;

    // Byte address split into cache fields
    typedef struct packed {
        logic [DCACHE_TAG_W-1:0]  tag;
        logic [DCACHE_IDX_W-1:0]  idx;
        logic [DCACHE_WOFF_W-1:0] word_off;
        logic [1:0]               byte_off;
    } dcache_addr_parts_t;

    // Same 32-bit address, seen raw or as tag/index/offsets
    typedef union packed {
        logic [31:0]        raw;
        dcache_addr_parts_t parts;
    } dcache_addr_u;

endpackage
